// File: build.f
+incdir+.
gsm_pkg.sv
cell_free_list.sv
cell_ingress.sv
ptr_queue.sv
gsm_ram.sv
egress_port.sv
gsm_switch_top.sv
tb_gsm_switch.sv

// File: cell_free_list.sv
// **************************************************
// free list of cell addresses
// circular buffer, preloaded with every slot in reset
// **************************************************
`timescale 1ns/1ps
`include "gsm_settings.svh"

module cell_free_list import gsm_pkg::*; (
	input  logic        clk,
	input  logic        i_rst_n,
	// allocation side
	input  logic        i_pop,
	output cell_addr_t  o_addr,
	output logic        o_empty,
	// release side
	input  logic        i_push,
	input  cell_addr_t  i_push_addr,
	// occupancy
	output fill_count_t o_count
);

	localparam int FL_DEPTH = 1 << `GSM_AWIDTH;

	cell_addr_t  mem [FL_DEPTH];
	cell_addr_t  rd_ptr;
	cell_addr_t  wr_ptr;
	fill_count_t count;

	// pointers are exactly AWIDTH wide, so they wrap on their own
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= fill_count_t'(FL_DEPTH);
			// every slot starts out free, in order
			for (int i = 0; i < FL_DEPTH; i++) begin
				mem[i] <= cell_addr_t'(i);
			end
		end else begin
			if (i_push) begin
				mem[wr_ptr] <= i_push_addr;
				wr_ptr      <= wr_ptr + 1'b1;
			end
			if (i_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// push and pop on one edge leave the count alone
			count <= count + fill_count_t'(i_push) - fill_count_t'(i_pop);
		end
	end

	// head of the list is the next address handed out
	assign o_addr  = mem[rd_ptr];
	assign o_empty = (count == '0);
	assign o_count = count;

	// ingress must not pop an empty list and the buffer must not return more than it took
	a_fl_bounds: assert property (@(posedge clk) disable iff (!i_rst_n)
		!(i_pop && o_empty) && !(i_push && !i_pop && count == fill_count_t'(FL_DEPTH)))
		else $error("free list overrun or underrun");

endmodule

// File: cell_ingress.sv
// **************************************************
// ingress port with valid/ready handshake
// drops empty-mask cells, allocates a slot for others
// **************************************************
`timescale 1ns/1ps

module cell_ingress import gsm_pkg::*; (
	input  logic       clk,
	input  logic       i_rst_n,
	// external cell source
	input  logic       i_cell_valid,
	input  port_mask_t i_cell_mask,
	input  cell_data_t i_cell_data,
	output logic       o_cell_ready,
	// free list
	input  logic       i_alloc_empty,
	input  cell_addr_t i_alloc_addr,
	output logic       o_alloc_pop,
	// combined memory write and queue push
	output logic       o_wr_en,
	output cell_addr_t o_wr_addr,
	output cell_data_t o_wr_data,
	output port_mask_t o_wr_mask
);

	logic mask_empty;
	logic accept;
	logic admit;

	// a cell with no destination needs no slot
	assign mask_empty = (i_cell_mask == '0);

	// ready only when a slot is free, unless the cell is dropped anyway
	assign o_cell_ready = !i_alloc_empty || mask_empty;

	assign accept = i_cell_valid && o_cell_ready;

	// only cells with at least one destination are stored
	assign admit = accept && !mask_empty;

	// **************************************************
	// write request towards the central buffer
	// **************************************************

	// slot leaves the free list on the accept edge
	assign o_alloc_pop = admit;

	// data, mask and pointer push all happen on that same edge
	assign o_wr_en   = admit;
	assign o_wr_addr = i_alloc_addr;
	assign o_wr_data = i_cell_data;
	assign o_wr_mask = i_cell_mask;

	// source keeps its cell steady until it is taken
	a_in_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
		(i_cell_valid && !o_cell_ready) |=>
		(i_cell_valid && $stable(i_cell_mask) && $stable(i_cell_data)))
		else $error("ingress cell changed while waiting for ready");

endmodule

// File: egress_port.sv
// **************************************************
// egress output fifo with valid/ready drain
// stall keeps room for reads already in flight
// **************************************************
`timescale 1ns/1ps
`include "gsm_settings.svh"

module egress_port import gsm_pkg::*; (
	input  logic       clk,
	input  logic       i_rst_n,
	// from the central buffer
	input  logic       i_load,
	input  cell_data_t i_data,
	output logic       o_stall,
	// to the link
	output logic       o_valid,
	output cell_data_t o_data,
	input  logic       i_ready
);

	localparam int PW = $clog2(`GSM_EGQ_DEPTH);

	cell_data_t  mem [`GSM_EGQ_DEPTH];
	logic [PW-1:0] rd_ptr;
	logic [PW-1:0] wr_ptr;
	logic [PW:0]   count;
	logic          drain;

	assign drain = o_valid && i_ready;

	always_ff @(posedge clk) begin
		if (i_load) begin
			mem[wr_ptr] <= i_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			wr_ptr <= wr_ptr + PW'(i_load);
			rd_ptr <= rd_ptr + PW'(drain);
			count  <= count + i_load - drain;
		end
	end

	assign o_valid = (count != '0);
	assign o_data  = mem[rd_ptr];
	// threshold leaves GSM_RD_DELAY slots for pending reads
	assign o_stall = (count >= (`GSM_EGQ_DEPTH - `GSM_RD_DELAY));

	a_eg_ovf: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_load |-> ((count < `GSM_EGQ_DEPTH) || drain))
		else $error("egress fifo overflow");

endmodule

// File: gsm_pkg.sv
// **************************************************
// shared types of the cell switch
// **************************************************
`include "gsm_settings.svh"

package gsm_pkg;

	// one cell payload word
	typedef logic [`GSM_DWIDTH-1:0] cell_data_t;

	// slot index in the central memory
	typedef logic [`GSM_AWIDTH-1:0] cell_addr_t;

	// one bit per egress port
	// used for the multicast mask, stall and select vectors
	typedef logic [`GSM_NPORTS-1:0] port_mask_t;

	// free list occupancy, one bit wider so a full list fits
	typedef logic [`GSM_AWIDTH:0] fill_count_t;

endpackage

// File: gsm_ram.sv
// **************************************************
// central cell buffer with per-port pointer queues
// round-robin read scheduling and slot release
// **************************************************
`timescale 1ns/1ps
`include "gsm_settings.svh"

module gsm_ram import gsm_pkg::*; (
	input  logic       clk,
	input  logic       i_rst_n,
	// write from ingress
	input  logic       i_wr_en,
	input  cell_addr_t i_wr_addr,
	input  cell_data_t i_wr_data,
	input  port_mask_t i_wr_mask,
	// egress side
	input  port_mask_t i_eg_stall,
	output port_mask_t o_eg_sel,
	output cell_data_t o_eg_data,
	// slot release to the free list
	output logic       o_rel_en,
	output cell_addr_t o_rel_addr
);

	localparam int NCELLS = 1 << `GSM_AWIDTH;

	typedef enum logic {IDLE, RUN} sched_state_t;

	sched_state_t state;
	port_mask_t   rot;
	port_mask_t   q_valid;
	port_mask_t   q_pop;
	cell_addr_t   q_addr [`GSM_NPORTS];
	cell_addr_t   rd_addr_nxt;
	cell_addr_t   rd_addr;
	port_mask_t   rd_sel;
	cell_data_t   mem [NCELLS];
	// pending destinations per slot
	port_mask_t   pend [NCELLS];
	// read pipeline stages
	cell_data_t   data_q [`GSM_RD_DELAY];
	cell_addr_t   addr_q [`GSM_RD_DELAY];
	port_mask_t   sel_q [`GSM_RD_DELAY];
	port_mask_t   out_sel;
	cell_addr_t   out_addr;
	port_mask_t   pend_left;

	// **************************************************
	// pointer queues, one per egress port
	// **************************************************
	for (genvar p = 0; p < `GSM_NPORTS; p++) begin : g_pq
		ptr_queue u_pq (
			.clk         (clk),
			.i_rst_n     (i_rst_n),
			.i_push      (i_wr_en && i_wr_mask[p]),
			.i_push_addr (i_wr_addr),
			.i_pop       (q_pop[p]),
			.o_valid     (q_valid[p]),
			.o_addr      (q_addr[p])
		);
	end

	// free list is preloaded during reset, so run right after
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state <= IDLE;
			rot   <= port_mask_t'(1);
		end else begin
			state <= RUN;
			if (state == RUN) begin
				rot <= {rot[`GSM_NPORTS-2:0], rot[`GSM_NPORTS-1]};
			end
		end
	end

	// selected queue pops when it has an address and its port has room
	assign q_pop = (state == RUN) ? (rot & q_valid & ~i_eg_stall) : '0;

	// at most one bit of q_pop is set
	always_comb begin
		rd_addr_nxt = q_addr[0];
		for (int p = 0; p < `GSM_NPORTS; p++) begin
			if (q_pop[p]) begin
				rd_addr_nxt = q_addr[p];
			end
		end
	end

	// **************************************************
	// memory write and read pipeline
	// **************************************************
	always_ff @(posedge clk) begin
		if (i_wr_en) begin
			mem[i_wr_addr] <= i_wr_data;
		end
		rd_addr   <= rd_addr_nxt;
		data_q[0] <= mem[rd_addr];
		addr_q[0] <= rd_addr;
		for (int s = 1; s < `GSM_RD_DELAY; s++) begin
			data_q[s] <= data_q[s-1];
			addr_q[s] <= addr_q[s-1];
		end
	end

	// select travels alongside the read data
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			rd_sel <= '0;
			for (int s = 0; s < `GSM_RD_DELAY; s++) begin
				sel_q[s] <= '0;
			end
		end else begin
			rd_sel   <= q_pop;
			sel_q[0] <= rd_sel;
			for (int s = 1; s < `GSM_RD_DELAY; s++) begin
				sel_q[s] <= sel_q[s-1];
			end
		end
	end

	assign out_sel   = sel_q[`GSM_RD_DELAY-1];
	assign out_addr  = addr_q[`GSM_RD_DELAY-1];
	assign o_eg_sel  = out_sel;
	assign o_eg_data = data_q[`GSM_RD_DELAY-1];

	// **************************************************
	// pending mask and release
	// **************************************************
	assign pend_left = pend[out_addr] & ~out_sel;

	// last destination served frees the slot
	assign o_rel_en   = (out_sel != '0) && (pend_left == '0);
	assign o_rel_addr = out_addr;

	// a slot being written is never one still being read
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			for (int a = 0; a < NCELLS; a++) begin
				pend[a] <= '0;
			end
		end else begin
			if (out_sel != '0) begin
				pend[out_addr] <= pend_left;
			end
			if (i_wr_en) begin
				pend[i_wr_addr] <= i_wr_mask;
			end
		end
	end

	a_pend_clr: assert property (@(posedge clk) disable iff (!i_rst_n)
		(out_sel != '0) |-> ((pend[out_addr] & out_sel) != '0))
		else $error("pending bit cleared twice");

endmodule

// File: gsm_settings.svh
// **************************************************
// global sizing for the shared-memory cell switch
// port count, cell width, buffer size, read latency
// **************************************************
`ifndef GSM_SETTINGS_SVH
`define GSM_SETTINGS_SVH

// egress port count, one mask bit per port
`define GSM_NPORTS 4
// cell payload width
`define GSM_DWIDTH 32
// cell address width, 16 slots in the central buffer
`define GSM_AWIDTH 4
// central memory read latency in cycles
`define GSM_RD_DELAY 2
// egress output fifo depth
`define GSM_EGQ_DEPTH 4

`endif

// File: gsm_switch_top.sv
// **************************************************
// switch top, ingress to central buffer to egress
// **************************************************
`timescale 1ns/1ps
`include "gsm_settings.svh"

module gsm_switch_top import gsm_pkg::*; (
	input  logic        clk,
	input  logic        i_rst_n,
	input  logic        i_cell_valid,
	input  port_mask_t  i_cell_mask,
	input  cell_data_t  i_cell_data,
	output logic        o_cell_ready,
	output port_mask_t  o_eg_valid,
	output cell_data_t  o_eg_data0,
	output cell_data_t  o_eg_data1,
	output cell_data_t  o_eg_data2,
	output cell_data_t  o_eg_data3,
	input  port_mask_t  i_eg_ready,
	output fill_count_t o_free_count
);

	logic       alloc_pop;
	logic       alloc_empty;
	cell_addr_t alloc_addr;
	logic       wr_en;
	cell_addr_t wr_addr;
	cell_data_t wr_data;
	port_mask_t wr_mask;
	logic       rel_en;
	cell_addr_t rel_addr;
	port_mask_t eg_sel;
	cell_data_t eg_data;
	port_mask_t eg_stall;
	cell_data_t eg_out [`GSM_NPORTS];

	cell_ingress u_ingress (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_cell_valid (i_cell_valid),
		.i_cell_mask  (i_cell_mask),
		.i_cell_data  (i_cell_data),
		.o_cell_ready (o_cell_ready),
		.i_alloc_empty(alloc_empty),
		.i_alloc_addr (alloc_addr),
		.o_alloc_pop  (alloc_pop),
		.o_wr_en      (wr_en),
		.o_wr_addr    (wr_addr),
		.o_wr_data    (wr_data),
		.o_wr_mask    (wr_mask)
	);

	cell_free_list u_free_list (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_pop       (alloc_pop),
		.o_addr      (alloc_addr),
		.o_empty     (alloc_empty),
		.i_push      (rel_en),
		.i_push_addr (rel_addr),
		.o_count     (o_free_count)
	);

	gsm_ram u_ram (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_wr_en    (wr_en),
		.i_wr_addr  (wr_addr),
		.i_wr_data  (wr_data),
		.i_wr_mask  (wr_mask),
		.i_eg_stall (eg_stall),
		.o_eg_sel   (eg_sel),
		.o_eg_data  (eg_data),
		.o_rel_en   (rel_en),
		.o_rel_addr (rel_addr)
	);

	// one output fifo per port, all fed from the shared read bus
	for (genvar p = 0; p < `GSM_NPORTS; p++) begin : g_eg
		egress_port u_eg (
			.clk     (clk),
			.i_rst_n (i_rst_n),
			.i_load  (eg_sel[p]),
			.i_data  (eg_data),
			.o_stall (eg_stall[p]),
			.o_valid (o_eg_valid[p]),
			.o_data  (eg_out[p]),
			.i_ready (i_eg_ready[p])
		);
	end

	assign o_eg_data0 = eg_out[0];
	assign o_eg_data1 = eg_out[1];
	assign o_eg_data2 = eg_out[2];
	assign o_eg_data3 = eg_out[3];

endmodule

// File: gsm_vectors.txt
// columns: hold flag (1 = egress ready held low) _ port mask _ cell data, all hex
// one cell per line, the hold flag marks the back-pressure phase
0_1_10000001
0_2_20000002
0_4_30000003
0_8_40000004
0_1_10000005
0_0_dead0006
0_3_50000007
0_f_60000008
0_0_dead0009
0_a_7000000a
0_5_8000000b
0_c_9000000c
1_f_a0000001
1_f_a0000002
1_f_a0000003
1_f_a0000004
1_1_a0000005
1_2_a0000006
1_4_a0000007
1_8_a0000008
1_3_a0000009
1_6_a000000a
1_c_a000000b
1_9_a000000c
1_5_a000000d
1_a_a000000e
1_1_a000000f
1_2_a0000010
1_4_a0000011
1_8_a0000012
1_f_a0000013
1_7_a0000014
1_e_a0000015
1_b_a0000016
0_0_dead0020
0_9_b0000021
0_6_b0000022
0_f_b0000023

// File: ptr_queue.sv
// **************************************************
// address queue of one egress port
// **************************************************
`timescale 1ns/1ps

module ptr_queue import gsm_pkg::*; (
	input  logic       clk,
	input  logic       i_rst_n,
	input  logic       i_push,
	input  cell_addr_t i_push_addr,
	input  logic       i_pop,
	output logic       o_valid,
	output cell_addr_t o_addr
);

	// one entry per buffer slot, so a push always fits
	localparam int PQ_DEPTH = 1 << $bits(cell_addr_t);

	cell_addr_t              mem [PQ_DEPTH];
	cell_addr_t              rd_ptr;
	cell_addr_t              wr_ptr;
	logic [$bits(cell_addr_t):0] count;
	logic [$bits(cell_addr_t):0] count_nxt;

	assign count_nxt = count + i_push - i_pop;

	always_ff @(posedge clk) begin
		if (i_push) begin
			mem[wr_ptr] <= i_push_addr;
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			rd_ptr  <= '0;
			wr_ptr  <= '0;
			count   <= '0;
			o_valid <= 1'b0;
		end else begin
			wr_ptr  <= wr_ptr + cell_addr_t'(i_push);
			rd_ptr  <= rd_ptr + cell_addr_t'(i_pop);
			count   <= count_nxt;
			// valid registered from the next count
			o_valid <= (count_nxt != '0);
		end
	end

	assign o_addr = mem[rd_ptr];

	a_pq_pop: assert property (@(posedge clk) disable iff (!i_rst_n) i_pop |-> o_valid)
		else $error("pointer queue popped while empty");

endmodule

// File: tb_gsm_switch.sv
// **************************************************
// self-checking testbench of the cell switch
// vector-driven ingress, random egress ready, model queues
// **************************************************
`timescale 1ns/1ps
`include "gsm_settings.svh"

module tb_gsm_switch import gsm_pkg::*; ();

	localparam int MAX_VEC = 64;
	localparam int MAX_EXP = 256;

	logic        clk;
	logic        i_rst_n;
	logic        i_cell_valid;
	port_mask_t  i_cell_mask;
	cell_data_t  i_cell_data;
	logic        o_cell_ready;
	port_mask_t  o_eg_valid;
	cell_data_t  o_eg_data0;
	cell_data_t  o_eg_data1;
	cell_data_t  o_eg_data2;
	cell_data_t  o_eg_data3;
	port_mask_t  i_eg_ready;
	fill_count_t o_free_count;

	// vector word is {hold flag, mask, data}
	logic [39:0] vecs [MAX_VEC];
	// expected words per port, written on accept and read on delivery
	cell_data_t  exp_mem [`GSM_NPORTS][MAX_EXP];
	int          exp_wr [`GSM_NPORTS];
	int          exp_rd [`GSM_NPORTS];
	int          nvec;
	int          vec_idx;
	int          err_data;
	int          err_count;
	int          err_other;
	int          low_cycles;
	int          idle_cycles;
	logic        vec_loaded;
	logic        hold_active;
	logic        hold_done;
	logic        saw_ready_low;
	logic        drop_pending;
	fill_count_t drop_count;
	logic [31:0] rnd;

	gsm_switch_top i_dut (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_cell_valid (i_cell_valid),
		.i_cell_mask  (i_cell_mask),
		.i_cell_data  (i_cell_data),
		.o_cell_ready (o_cell_ready),
		.o_eg_valid   (o_eg_valid),
		.o_eg_data0   (o_eg_data0),
		.o_eg_data1   (o_eg_data1),
		.o_eg_data2   (o_eg_data2),
		.o_eg_data3   (o_eg_data3),
		.i_eg_ready   (i_eg_ready),
		.o_free_count (o_free_count)
	);

	// 100 ns period
	always #50 clk = ~clk;

	function automatic logic [31:0] next_random(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic cell_data_t eg_word(input int p);
		case (p)
			0: return o_eg_data0;
			1: return o_eg_data1;
			2: return o_eg_data2;
			default: return o_eg_data3;
		endcase
	endfunction

	function automatic logic models_empty();
		for (int p = 0; p < `GSM_NPORTS; p++) begin
			if (exp_rd[p] != exp_wr[p]) return 1'b0;
		end
		return 1'b1;
	endfunction

	task automatic check_data(input string name, input cell_data_t expected,
		input cell_data_t actual);
		if (actual !== expected) begin
			err_data++;
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_count(input string name, input fill_count_t expected,
		input fill_count_t actual);
		if (actual !== expected) begin
			err_count++;
			$display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic print_error_counts();
		$display("errors: data %0d, count %0d, other %0d", err_data, err_count, err_other);
	endtask

	// **************************************************
	// falling edge drive and pre-edge sampling
	// **************************************************
	task automatic drive_inputs();
		// hold phase keeps every egress blocked until ingress backs off
		hold_active = (vec_idx < nvec) && (vecs[vec_idx][39:36] != 4'h0) && !hold_done;
		if (vec_idx < nvec) begin
			i_cell_valid = 1'b1;
			i_cell_mask  = vecs[vec_idx][35:32];
			i_cell_data  = vecs[vec_idx][31:0];
		end else begin
			i_cell_valid = 1'b0;
			i_cell_mask  = '0;
			i_cell_data  = '0;
		end
		rnd = next_random(rnd);
		if (hold_active) begin
			i_eg_ready = '0;
		end else begin
			// mostly ready, with some random back-pressure
			i_eg_ready = rnd[19:16] | rnd[27:24];
		end
	endtask

	task automatic sample_transfers();
		// a dropped cell on the last edge must not have taken a slot
		if (drop_pending && (o_free_count < drop_count)) begin
			err_other++;
			$display("free count fell from %0d to %0d after a dropped cell",
				drop_count, o_free_count);
		end
		drop_pending = 1'b0;
		if (i_cell_valid && o_cell_ready) begin
			for (int p = 0; p < `GSM_NPORTS; p++) begin
				if (i_cell_mask[p]) begin
					exp_mem[p][exp_wr[p]] = i_cell_data;
					exp_wr[p]++;
				end
			end
			if (i_cell_mask == '0) begin
				drop_pending = 1'b1;
				drop_count   = o_free_count;
			end
			vec_idx++;
		end
		for (int p = 0; p < `GSM_NPORTS; p++) begin
			if (o_eg_valid[p] && i_eg_ready[p]) begin
				if (exp_rd[p] == exp_wr[p]) begin
					err_other++;
					$display("port %0d delivered word %h that no cell sent there", p, eg_word(p));
				end else begin
					check_data($sformatf("port%0d_word%0d", p, exp_rd[p]),
						exp_mem[p][exp_rd[p]], eg_word(p));
					exp_rd[p]++;
				end
			end
		end
		// release the hold once ingress has been refused for a while
		if (hold_active && !o_cell_ready) begin
			saw_ready_low = 1'b1;
			low_cycles++;
			if (low_cycles >= 8) hold_done = 1'b1;
		end
		if ((vec_idx == nvec) && models_empty() && (o_eg_valid == '0)) begin
			idle_cycles++;
		end else begin
			idle_cycles = 0;
		end
	endtask

	// **************************************************
	// main sequence
	// **************************************************
	initial begin
		clk           = 1'b0;
		i_rst_n       = 1'b0;
		i_cell_valid  = 1'b0;
		i_cell_mask   = '0;
		i_cell_data   = '0;
		i_eg_ready    = '0;
		vec_loaded    = 1'b0;
		hold_done     = 1'b0;
		saw_ready_low = 1'b0;
		drop_pending  = 1'b0;
		drop_count    = '0;
		err_data      = 0;
		err_count     = 0;
		err_other     = 0;
		low_cycles    = 0;
		idle_cycles   = 0;
		vec_idx       = 0;
		nvec          = 0;
		rnd           = 32'd33061;
		for (int p = 0; p < `GSM_NPORTS; p++) begin
			exp_wr[p] = 0;
			exp_rd[p] = 0;
		end
		$readmemh("gsm_vectors.txt", vecs);
		// unread entries stay unknown
		while ((nvec < MAX_VEC) && !$isunknown(vecs[nvec])) nvec++;
		if (nvec == 0) begin
			err_other++;
			$display("no cells were read from the vector file");
		end
		vec_loaded = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		i_rst_n = 1'b1;
		check_count("reset_free_count", fill_count_t'(1 << `GSM_AWIDTH), o_free_count);
		if (o_eg_valid !== '0) begin
			err_other++;
			$display("egress valid is high right after reset");
		end
		while (idle_cycles < 20) begin
			@(negedge clk);
			drive_inputs();
			#10;
			sample_transfers();
		end
		if (!saw_ready_low) begin
			err_other++;
			$display("ingress ready never fell while egress was held");
		end
		// every slot must be back once all ports drained
		check_count("final_free_count", fill_count_t'(1 << `GSM_AWIDTH), o_free_count);
		print_error_counts();
		if ((err_data + err_count + err_other) == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// watchdog sized from the vector count
	initial begin
		wait (vec_loaded === 1'b1);
		repeat (nvec * `GSM_NPORTS * 20 + 200) @(posedge clk);
		$display("timeout: the switch did not deliver every cell in time");
		print_error_counts();
		$display("test failed");
		$finish;
	end

endmodule
